//--- sim.f
verilog/rvCorePkg.sv
verilog/decodedIf.sv
verilog/instrDecode.sv
verilog/aluExecute.sv
verilog/regResult.sv
verilog/rvIntCore.sv
tests/clockGen.sv
tests/rvIntCoreTb.sv

//--- tests/rvIntCoreTb.sv
// Testbench for rvIntCore: stimulus, reference model, scoreboard, checks
`timescale 1ns/1ps

module rvIntCoreTb;

        logic                  clk;
        logic                  reset;
        rvCorePkg::instrWord_t instr;
        logic                  instrValid;
        logic                  wbValid;
        rvCorePkg::regId_t     wbRdId;
        rvCorePkg::xlenWord_t  wbData;

        // Model register file where x0 is never written
        rvCorePkg::xlenWord_t model [rvCorePkg::NUM_REGS];

        // Expected write-backs in issue order
        rvCorePkg::regId_t    expRd [$];
        rvCorePkg::xlenWord_t expData [$];
        int                   expEdge [$];

        integer seed;
        int     edgeCount;
        int     checks;
        int     valueErrors;
        int     otherErrors;

        clockGen clockSource (.clk(clk), .reset(reset));

        rvIntCore uut (
                .clk        (clk),
                .reset      (reset),
                .instr      (instr),
                .instrValid (instrValid),
                .wbValid    (wbValid),
                .wbRdId     (wbRdId),
                .wbData     (wbData)
        );

        function automatic rvCorePkg::instrWord_t registerOp(input logic [6:0] f7,
                        input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
                        input logic [4:0] rd);
                return {f7, rs2, rs1, f3, rd, rvCorePkg::OP_ALUREG};
        endfunction

        function automatic rvCorePkg::instrWord_t immediateOp(input logic [11:0] imm,
                        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
                return {imm, rs1, f3, rd, rvCorePkg::OP_ALUIMM};
        endfunction

        function automatic rvCorePkg::instrWord_t luiOp(input logic [19:0] imm,
                        input logic [4:0] rd);
                return {imm, rd, rvCorePkg::OP_LUI};
        endfunction

        // ISA result of one instruction against the model registers
        function automatic rvCorePkg::xlenWord_t refResult(input rvCorePkg::instrWord_t w);
                rvCorePkg::xlenWord_t a;
                rvCorePkg::xlenWord_t b;
                logic [4:0]           sh;
                logic                 isReg;
                if (w[6:0] == rvCorePkg::OP_LUI)
                        return {w[31:12], 12'b0};
                isReg = (w[6:0] == rvCorePkg::OP_ALUREG);
                a = model[w[19:15]];
                b = isReg ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
                sh = b[4:0];
                case (w[14:12])
                        3'b000: return (isReg && w[30]) ? a - b : a + b;
                        3'b001: return a << sh;
                        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b011: return (a < b) ? 32'd1 : 32'd0;
                        3'b100: return a ^ b;
                        3'b101: begin
                                // Bit 30 selects SRA over SRL
                                if (w[30])
                                        return $signed(a) >>> sh;
                                return a >> sh;
                        end
                        3'b110: return a | b;
                        default: return a & b;
                endcase
        endfunction

        // Random ALU instruction on x0..x7 with legal shift encodings
        function automatic rvCorePkg::instrWord_t randomAlu(input logic regForm);
                logic [31:0] rnd;
                logic [11:0] imm;
                logic [2:0]  f3;
                rnd = $random(seed);
                imm = rnd[31:20];
                f3 = rnd[11:9];
                if (regForm)
                        return registerOp((rnd[12] && (f3 == 3'b000 || f3 == 3'b101)) ?
                                          7'h20 : 7'h00,
                                          {2'b00, rnd[8:6]}, {2'b00, rnd[5:3]}, f3,
                                          {2'b00, rnd[2:0]});
                if (f3 == 3'b001)
                        imm = {7'b0, imm[4:0]};
                if (f3 == 3'b101)
                        imm = {1'b0, rnd[12], 5'b0, imm[4:0]};
                return immediateOp(imm, {2'b00, rnd[5:3]}, f3, {2'b00, rnd[2:0]});
        endfunction

        // One instruction on the next falling edge with the model run in issue order
        task automatic issue(input rvCorePkg::instrWord_t w);
                logic kept;
                @(negedge clk);
                instr = w;
                instrValid = 1'b1;
                kept = (w[6:0] == rvCorePkg::OP_ALUREG) || (w[6:0] == rvCorePkg::OP_ALUIMM) ||
                       (w[6:0] == rvCorePkg::OP_LUI);
                if (kept && w[11:7] != 5'd0) begin
                        model[w[11:7]] = refResult(w);
                        expRd.push_back(w[11:7]);
                        expData.push_back(model[w[11:7]]);
                        // Sampling edge is the next one and the result is seen two edges later
                        expEdge.push_back(edgeCount + 3);
                end
        endtask

        task automatic idle(input int cycles);
                repeat (cycles) begin
                        @(negedge clk);
                        instrValid = 1'b0;
                        instr = $random(seed);
                end
        endtask

        // Scoreboard at every rising edge
        always @(posedge clk) begin : scoreboard
                rvCorePkg::regId_t    rdExp;
                rvCorePkg::xlenWord_t dataExp;
                int                   edgeExp;
                edgeCount++;
                if (!reset && wbValid !== 1'b0) begin
                        assert (expRd.size() != 0) else begin
                                otherErrors++;
                                $display("%0t: write-back to x%0d arrived with nothing expected",
                                         $time, wbRdId);
                        end
                        if (expRd.size() != 0) begin
                                rdExp = expRd.pop_front();
                                dataExp = expData.pop_front();
                                edgeExp = expEdge.pop_front();
                                checks++;
                                assert (wbRdId === rdExp) else begin
                                        valueErrors++;
                                        $display("[FAIL] %0t wbRdId expected %0d got %0d",
                                                 $time, rdExp, wbRdId);
                                end
                                assert (wbData === dataExp) else begin
                                        valueErrors++;
                                        $display("[FAIL] %0t wbData expected %h got %h",
                                                 $time, dataExp, wbData);
                                end
                                assert (edgeCount == edgeExp) else begin
                                        otherErrors++;
                                        $display("%0t: result for x%0d came at edge %0d, not %0d",
                                                 $time, rdExp, edgeCount, edgeExp);
                                end
                        end
                end
        end

        initial begin
                int                    waitCycles;
                int                    r;
                int                    next;
                logic [31:0]           rnd;
                rvCorePkg::instrWord_t w;
                seed = 32'hf13325c0;
                instr = '0;
                instrValid = 1'b0;
                edgeCount = 0;
                checks = 0;
                valueErrors = 0;
                otherErrors = 0;
                for (int i = 0; i < rvCorePkg::NUM_REGS; i++)
                        model[i] = '0;

                waitCycles = 0;
                while (reset !== 1'b0 && waitCycles < 20) begin
                        @(negedge clk);
                        waitCycles++;
                end
                assert (reset === 1'b0) else begin
                        otherErrors++;
                        $display("Reset was never released");
                end

                // Quiet pipeline where any write-back is unexpected
                idle(6);

                // Immediate forms including negative immediates and SRAI
                repeat (40)
                        issue(randomAlu(1'b0));

                // SLT against SLTU with mixed signs, SUB, SRA, SRL
                issue(luiOp(20'h80000, 5'd1));
                issue(immediateOp(12'd5, 5'd0, 3'b000, 5'd2));
                issue(registerOp(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
                issue(registerOp(7'h00, 5'd2, 5'd1, 3'b011, 5'd4));
                issue(registerOp(7'h20, 5'd1, 5'd2, 3'b000, 5'd5));
                issue(registerOp(7'h20, 5'd2, 5'd1, 3'b101, 5'd6));
                issue(registerOp(7'h00, 5'd2, 5'd1, 3'b101, 5'd7));
                repeat (40)
                        issue(randomAlu(1'b1));

                // Back-to-back chain through rs1 and rs2
                r = 1;
                repeat (12) begin
                        next = (r % 7) + 1;
                        issue(immediateOp(12'hff3, r[4:0], 3'b000, next[4:0]));
                        issue(registerOp(7'h20, next[4:0], 5'd3, 3'b000, next[4:0]));
                        r = next;
                end

                // Second of each pair reads the first rd through the register file
                repeat (8) begin
                        w = randomAlu(1'b1);
                        if (w[11:7] == 5'd0)
                                w[7] = 1'b1;
                        issue(w);
                        idle(1);
                        issue(registerOp(7'h00, w[11:7], 5'd5, 3'b100, 5'd5));
                end

                // LUI, x0 writes, unsupported opcodes, then reads of x0
                issue(luiOp(20'hfedcb, 5'd9));
                issue(luiOp(20'h12345, 5'd0));
                issue(immediateOp(12'h7ff, 5'd9, 3'b000, 5'd0));
                issue({25'h1234567, 7'b0000011});
                issue({25'h0abcdef, 7'b1100011});
                issue({25'h0000073, 7'b1110011});
                issue(registerOp(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));
                issue(registerOp(7'h00, 5'd0, 5'd9, 3'b110, 5'd10));

                // Random mix with random gaps
                repeat (60) begin
                        r = $random(seed);
                        rnd = $random(seed);
                        case (r[1:0])
                                2'd0: issue(randomAlu(1'b1));
                                2'd1: issue(randomAlu(1'b0));
                                2'd2: issue(luiOp(rnd[19:0], r[6:2]));
                                default: issue({rnd[24:0], r[2] ? 7'b0000011 : 7'b1100011});
                        endcase
                        if (r[9:8] != 2'd0)
                                idle(r[9:8]);
                end
                idle(1);

                // Drain the expected queue
                waitCycles = 0;
                while (expRd.size() != 0 && waitCycles < 50) begin
                        @(negedge clk);
                        waitCycles++;
                end
                assert (expRd.size() == 0) else begin
                        otherErrors++;
                        $display("Timed out with %0d write-backs still outstanding", expRd.size());
                end
                idle(4);

                $display("Checks %0d, value errors %0d, other errors %0d",
                         checks, valueErrors, otherErrors);
                if (valueErrors == 0 && otherErrors == 0) begin
                        $display("TESTS PASSED");
                end else begin
                        $display("TESTS FAILED");
                end
                $finish;
        end

endmodule

//--- tests/clockGen.sv
// Testbench clock, 10 ns period, and synchronous reset held for two cycles
`timescale 1ns/1ps

module clockGen (
        output logic clk,
        output logic reset
);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // Two rising edges in reset, released on a falling edge
        initial begin
                reset = 1'b1;
                repeat (2) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
        end

endmodule

//--- verilog/rvIntCore.sv
// Top level of the integer core: decode, execute and result stages
`timescale 1ns/1ps

module rvIntCore (
        input  logic                  clk,
        input  logic                  reset,
        input  rvCorePkg::instrWord_t instr,
        input  logic                  instrValid,
        output logic                  wbValid,
        output rvCorePkg::regId_t     wbRdId,
        output rvCorePkg::xlenWord_t  wbData
);

        // Register file reads for the instruction in execute
        rvCorePkg::xlenWord_t rs1Data;
        rvCorePkg::xlenWord_t rs2Data;

        // Execute output register
        logic                 resValid;
        rvCorePkg::regId_t    resRd;
        rvCorePkg::xlenWord_t resData;

        decodedIf dec ();

        instrDecode decodeStage (
                .clk        (clk),
                .reset      (reset),
                .instr      (instr),
                .instrValid (instrValid),
                .dec        (dec.producer)
        );

        aluExecute executeStage (
                .clk      (clk),
                .reset    (reset),
                .dec      (dec.consumer),
                .rs1Data  (rs1Data),
                .rs2Data  (rs2Data),
                .resValid (resValid),
                .resRd    (resRd),
                .resData  (resData)
        );

        // Read indices come straight off the decode register
        regResult resultStage (
                .clk      (clk),
                .reset    (reset),
                .resValid (resValid),
                .resRd    (resRd),
                .resData  (resData),
                .rs1      (dec.rs1),
                .rs2      (dec.rs2),
                .rs1Data  (rs1Data),
                .rs2Data  (rs2Data),
                .wbValid  (wbValid),
                .wbRdId   (wbRdId),
                .wbData   (wbData)
        );

endmodule

//--- verilog/regResult.sv
// Result stage: register file with write-back, asynchronous read ports, write-back outputs
`timescale 1ns/1ps

module regResult (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  resValid,
        input  rvCorePkg::regId_t     resRd,
        input  rvCorePkg::xlenWord_t  resData,
        input  rvCorePkg::regId_t     rs1,
        input  rvCorePkg::regId_t     rs2,
        output rvCorePkg::xlenWord_t  rs1Data,
        output rvCorePkg::xlenWord_t  rs2Data,
        output logic                  wbValid,
        output rvCorePkg::regId_t     wbRdId,
        output rvCorePkg::xlenWord_t  wbData
);

        rvCorePkg::xlenWord_t regs [rvCorePkg::NUM_REGS];

        // Cleared on reset so early reads are defined
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < rvCorePkg::NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (resValid && (resRd != '0)) begin
                        regs[resRd] <= resData;
                end
        end

        // Async reads, x0 hardwired
        assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
        assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

        // Visible write equals the one stored at the next edge
        assign wbValid = resValid;
        assign wbRdId  = resRd;
        assign wbData  = resData;

endmodule

//--- verilog/aluExecute.sv
// Execute stage: operand forwarding, ALU, execute output register
`timescale 1ns/1ps

module aluExecute (
        input  logic                  clk,
        input  logic                  reset,
        decodedIf.consumer            dec,
        input  rvCorePkg::xlenWord_t  rs1Data,
        input  rvCorePkg::xlenWord_t  rs2Data,
        output logic                  resValid,
        output rvCorePkg::regId_t     resRd,
        output rvCorePkg::xlenWord_t  resData
);

        logic                         fwdRs1;
        logic                         fwdRs2;
        rvCorePkg::xlenWord_t         opA;
        rvCorePkg::xlenWord_t         rs2Value;
        rvCorePkg::xlenWord_t         opB;
        logic                         isSub;
        logic [rvCorePkg::XLEN:0]     diff;
        rvCorePkg::xlenWord_t         addSub;
        logic                         ltSigned;
        logic                         ltUnsigned;
        logic [rvCorePkg::SHAMT_BITS-1:0] shamt;
        rvCorePkg::xlenWord_t         shiftLeft;
        logic [rvCorePkg::XLEN:0]     shiftIn;
        logic [rvCorePkg::XLEN:0]     shiftRight;
        rvCorePkg::xlenWord_t         aluOut;

        // Bypass from our own output register
        // resValid already excludes x0
        assign fwdRs1 = resValid && (resRd == dec.rs1);
        assign fwdRs2 = resValid && (resRd == dec.rs2);

        assign opA      = fwdRs1 ? resData : rs1Data;
        assign rs2Value = fwdRs2 ? resData : rs2Data;

        // Second operand is rs2 or the immediate
        assign opB = dec.useImm ? dec.imm : rs2Value;

        // SUB only in register form as ADDI ignores bit 30
        assign isSub = dec.altOp && !dec.useImm;

        // Wide subtract with the borrow in the top bit
        assign diff   = {1'b0, opA} - {1'b0, opB};
        assign addSub = isSub ? diff[rvCorePkg::XLEN-1:0] : opA + opB;

        // Compares
        assign ltUnsigned = diff[rvCorePkg::XLEN];
        assign ltSigned   = (opA[rvCorePkg::XLEN-1] ^ opB[rvCorePkg::XLEN-1]) ?
                            opA[rvCorePkg::XLEN-1] : diff[rvCorePkg::XLEN];

        // Shifts use low bits of opB only
        assign shamt     = opB[rvCorePkg::SHAMT_BITS-1:0];
        assign shiftLeft = opA << shamt;

        // Extra top bit fills with the sign for SRA and with zero for SRL
        assign shiftIn    = {dec.altOp & opA[rvCorePkg::XLEN-1], opA};
        assign shiftRight = $signed(shiftIn) >>> shamt;

        always_comb begin
                case (dec.funct3)
                        // ADD / SUB / ADDI
                        3'b000: aluOut = addSub;
                        // SLL
                        3'b001: aluOut = shiftLeft;
                        // SLT
                        3'b010: aluOut = {{(rvCorePkg::XLEN-1){1'b0}}, ltSigned};
                        // SLTU
                        3'b011: aluOut = {{(rvCorePkg::XLEN-1){1'b0}}, ltUnsigned};
                        3'b100: aluOut = opA ^ opB;
                        // SRL / SRA
                        3'b101: aluOut = shiftRight[rvCorePkg::XLEN-1:0];
                        3'b110: aluOut = opA | opB;
                        3'b111: aluOut = opA & opB;
                endcase
        end

        // x0 destinations never leave this stage
        always_ff @(posedge clk) begin
                if (reset) begin
                        resValid <= 1'b0;
                end else begin
                        resValid <= dec.valid && (dec.rd != '0);
                end
        end

        // Result payload
        always_ff @(posedge clk) begin
                if (dec.valid) begin
                        resRd   <= dec.rd;
                        resData <= dec.isLui ? dec.imm : aluOut;
                end
        end

endmodule

//--- verilog/instrDecode.sv
// Decode stage: instruction register, opcode filter, field and immediate extraction
`timescale 1ns/1ps

module instrDecode (
        input  logic                   clk,
        input  logic                   reset,
        input  rvCorePkg::instrWord_t  instr,
        input  logic                   instrValid,
        decodedIf.producer             dec
);

        rvCorePkg::opcode_t   opcode;
        logic                 isAluReg;
        logic                 isAluImm;
        logic                 isLui;
        logic                 keep;
        rvCorePkg::xlenWord_t iImm;
        rvCorePkg::xlenWord_t uImm;

        assign opcode = instr[rvCorePkg::OPCODE_LSB +: rvCorePkg::OPCODE_BITS];

        // Opcode classes this unit executes
        assign isAluReg = (opcode == rvCorePkg::OP_ALUREG);
        assign isAluImm = (opcode == rvCorePkg::OP_ALUIMM);
        assign isLui    = (opcode == rvCorePkg::OP_LUI);

        // Anything else is silently dropped
        assign keep = isAluReg || isAluImm || isLui;

        // Sign extended from bit 31
        assign iImm = {{(rvCorePkg::XLEN - rvCorePkg::IIMM_BITS){instr[rvCorePkg::XLEN-1]}},
                       instr[rvCorePkg::IIMM_LSB +: rvCorePkg::IIMM_BITS]};

        // Upper 20 bits, zero fill below
        assign uImm = {instr[rvCorePkg::XLEN-1:rvCorePkg::UIMM_LSB],
                       {rvCorePkg::UIMM_LSB{1'b0}}};

        // Valid only for kept opcodes
        always_ff @(posedge clk) begin
                if (reset) begin
                        dec.valid <= 1'b0;
                end else begin
                        dec.valid <= instrValid && keep;
                end
        end

        // Payload, loaded on every strobe
        always_ff @(posedge clk) begin
                if (instrValid) begin
                        dec.rd     <= instr[rvCorePkg::RD_LSB +: rvCorePkg::REG_ID_BITS];
                        dec.rs2    <= instr[rvCorePkg::RS2_LSB +: rvCorePkg::REG_ID_BITS];
                        dec.funct3 <= instr[rvCorePkg::FUNCT3_LSB +: 3];
                        dec.altOp  <= instr[rvCorePkg::ALT_BIT];
                        dec.useImm <= isAluImm;
                        dec.isLui  <= isLui;

                        // LUI has no rs1, keep x0 so forwarding never matches
                        if (isLui) begin
                                dec.rs1 <= '0;
                                dec.imm <= uImm;
                        end else begin
                                dec.rs1 <= instr[rvCorePkg::RS1_LSB +: rvCorePkg::REG_ID_BITS];
                                dec.imm <= iImm;
                        end
                end
        end

endmodule

//--- verilog/decodedIf.sv
// Decoded instruction interface between decode and execute, with producer and consumer modports
`timescale 1ns/1ps

interface decodedIf;

        // Qualifier, no handshake back to decode
        logic valid;

        // Register indices
        rvCorePkg::regId_t rd;
        rvCorePkg::regId_t rs1;
        rvCorePkg::regId_t rs2;

        // Operation select
        rvCorePkg::funct3_t funct3;
        logic altOp;
        logic useImm;
        logic isLui;

        // I-immediate, or U-immediate for LUI
        rvCorePkg::xlenWord_t imm;

        modport producer (output valid, rd, rs1, rs2, funct3, altOp, useImm, isLui, imm);

        modport consumer (input valid, rd, rs1, rs2, funct3, altOp, useImm, isLui, imm);

endinterface

//--- verilog/rvCorePkg.sv
// Core package: data types, opcode constants, instruction field positions, register file size
package rvCorePkg;

        // Machine word width
        localparam int XLEN = 32;

        // Register index width, x0..x31
        localparam int REG_ID_BITS = 5;

        // Register file depth
        localparam int NUM_REGS = 1 << REG_ID_BITS;

        // Shift amount width for RV32
        localparam int SHAMT_BITS = 5;

        // Opcode field
        localparam int OPCODE_LSB  = 0;
        localparam int OPCODE_BITS = 7;

        // Data and instruction words
        typedef logic [XLEN-1:0] xlenWord_t;
        typedef logic [31:0] instrWord_t;

        // Register index and operation selector
        typedef logic [REG_ID_BITS-1:0] regId_t;
        typedef logic [2:0] funct3_t;

        // Major opcode
        typedef logic [OPCODE_BITS-1:0] opcode_t;

        // Kept opcodes, everything else is dropped in decode
        localparam opcode_t OP_ALUREG = 7'b0110011;
        localparam opcode_t OP_ALUIMM = 7'b0010011;
        localparam opcode_t OP_LUI    = 7'b0110111;

        // Field positions inside the instruction word
        localparam int RD_LSB     = 7;
        localparam int FUNCT3_LSB = 12;
        localparam int RS1_LSB    = 15;
        localparam int RS2_LSB    = 20;

        // funct7 bit that selects SUB and SRA/SRAI
        localparam int ALT_BIT = 30;

        // I-immediate sits in the top 12 bits
        localparam int IIMM_LSB  = 20;
        localparam int IIMM_BITS = 12;

        // U-immediate is the top 20 bits, low 12 are zero
        localparam int UIMM_LSB = 12;

endpackage
